// ==== verilog/pipe_isa_pkg.sv ====
/*
 * tiny_pipe instruction set: data and address widths, instruction
 * field positions and the opcode encoding of the five instructions
 */

package pipe_isa_pkg;

  // ==============================
  // widths
  // ==============================

  localparam int WORD_W  = 16;
  localparam int INSTR_W = 16;
  localparam int RADDR_W = 3;
  localparam int PC_W    = 8;
  localparam int IMM_W   = 7;
  localparam int OP_W    = 3;

  typedef logic [WORD_W-1:0]         word_t;
  typedef logic [INSTR_W-1:0]        instr_t;
  typedef logic [RADDR_W-1:0]        reg_addr_t;
  typedef logic [PC_W-1:0]           pc_t;
  typedef logic signed [IMM_W-1:0]   imm_t;

  // ==============================
  // instruction fields
  // ==============================

  // opcode sits in the top three bits, then rd, rs and the low field
  localparam int OP_LSB  = 13;
  localparam int RD_LSB  = 10;
  localparam int RS_LSB  = 7;
  // rt for ADD and MUL is the low three bits of the immediate field
  localparam int RT_LSB  = 0;
  localparam int IMM_LSB = 0;

  typedef enum logic [OP_W-1:0] {
    NOP  = 3'd0,
    ADD  = 3'd1,
    ADDI = 3'd2,
    MUL  = 3'd3,
    JMP  = 3'd4
  } opcode_e;

endpackage

// ==== verilog/pipe_cfg_pkg.sv ====
/*
 * tiny_pipe microarchitecture constants and the state encoding of the
 * iterative multiplier in execute
 */

package pipe_cfg_pkg;

  // size of the register file
  localparam int NUM_REGS = 8;

  // first instruction address fetched after reset
  localparam int unsigned RESET_PC = 0;

  // cycles a MUL spends in execute
  localparam int MUL_CYCLES = 3;
  // multiplier bits consumed per cycle, ceil(16 / MUL_CYCLES)
  localparam int MUL_STEP_BITS = 6;
  // width of the step counter, enough to count to MUL_CYCLES-1
  localparam int MUL_CNT_W = 2;

  // multiplier sequencing in execute
  typedef enum logic {
    IDLE     = 1'b0,
    MUL_BUSY = 1'b1
  } exec_state_e;

endpackage

// ==== verilog/pipe_ctrl.sv ====
/*
 * pipe_ctrl holds the valid bit of one pipeline stage and combines the
 * stall and squash requests of this stage and the stages behind it
 */

`timescale 1ns/1ps

module pipe_ctrl (
  input  logic clk,
  input  logic rst_n,

  // valid bit from the previous stage
  input  logic prev_val,
  // combined stall and squash going to the previous stage
  output logic prev_stall,
  output logic prev_squash,

  // enable for this stage's payload registers
  output logic curr_reg_en,
  output logic curr_val,
  input  logic curr_stall,
  input  logic curr_squash,

  // valid bit toward the next stage and its requests back to us
  output logic next_val,
  input  logic next_stall,
  input  logic next_squash
);

  logic val_en;

  // ==============================
  // valid bit
  // ==============================

  // the valid bit moves whenever this stage is free to advance, and a
  // squash from downstream always forces the load so the bubble lands
  assign val_en = !prev_stall || next_squash;

  // payload registers only need to load when a real instruction arrives
  assign curr_reg_en = (!prev_stall && prev_val) || next_squash;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      curr_val <= 1'b0;
    end else if (val_en) begin
      // a squashed slot comes in empty whatever the previous stage offered
      curr_val <= prev_val && !next_squash;
    end
  end

  // ==============================
  // stall and squash aggregation
  // ==============================

  // an instruction leaves only if nothing holds it and nothing kills it
  assign next_val = curr_val && !next_squash && !next_stall && !curr_stall;

  // bubbles never stall, and a stage being squashed has nothing to hold
  assign prev_stall = (next_stall || curr_stall) && curr_val && !next_squash;

  // our own squash is only issued once this stage really moves on,
  // otherwise a stalled squasher would fire again on the next cycle
  assign prev_squash = next_squash || (curr_squash && !next_stall && !curr_stall);

endmodule

// ==== verilog/fetch_stage.sv ====
/*
 * fetch stage: keeps the PC, captures the instruction from instruction
 * memory and jumps to the redirect target when execute squashes
 */

`timescale 1ns/1ps

module fetch_stage
  import pipe_isa_pkg::*, pipe_cfg_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   next_stall,
  input  logic   next_squash,
  input  pc_t    redirect_pc,
  input  instr_t imem_data,
  output pc_t    imem_addr,
  output logic   f_val,
  output instr_t f_instr,
  output pc_t    f_pc
);

  logic f_reg_en;
  pc_t  pc;

  // fetch always has a new instruction to offer and raises no requests
  pipe_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .prev_val    (1'b1),
    .prev_stall  (),
    .prev_squash (),
    .curr_reg_en (f_reg_en),
    .curr_val    (),
    .curr_stall  (1'b0),
    .curr_squash (1'b0),
    .next_val    (f_val),
    .next_stall  (next_stall),
    .next_squash (next_squash)
  );

  // the PC steps along with the fetch register, a squash swaps in the
  // jump target so it shows on imem_addr right after the edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= pc_t'(RESET_PC);
    end else if (f_reg_en) begin
      pc <= next_squash ? redirect_pc : pc + 1'b1;
    end
  end

  assign imem_addr = pc;

  // instruction memory answers in the same cycle, so capture it directly
  always_ff @(posedge clk) begin
    if (f_reg_en) begin
      f_instr <= imem_data;
      f_pc    <= pc;
    end
  end

endmodule

// ==== verilog/decode_stage.sv ====
/*
 * decode stage: register file with write-through, field decode, operand
 * read and the read-after-write interlock against execute
 */

`timescale 1ns/1ps

module decode_stage
  import pipe_isa_pkg::*, pipe_cfg_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      f_val,
  input  instr_t    f_instr,
  input  pc_t       f_pc,
  input  logic      next_stall,
  input  logic      next_squash,
  input  reg_addr_t x_dest,
  input  logic      x_dest_val,
  input  logic      rf_wen,
  input  reg_addr_t rf_waddr,
  input  word_t     rf_wdata,
  output logic      prev_stall,
  output logic      prev_squash,
  output logic      d_val,
  output opcode_e   d_op,
  output reg_addr_t d_rd,
  output word_t     d_a,
  output word_t     d_b,
  output pc_t       d_pc
);

  logic      d_reg_en;
  logic      raw_stall;
  instr_t    d_instr;
  reg_addr_t rs;
  reg_addr_t rt;
  imm_t      imm;
  word_t     rf [NUM_REGS];
  word_t     rt_data;

  pipe_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .prev_val    (f_val),
    .prev_stall  (prev_stall),
    .prev_squash (prev_squash),
    .curr_reg_en (d_reg_en),
    .curr_val    (),
    .curr_stall  (raw_stall),
    .curr_squash (1'b0),
    .next_val    (d_val),
    .next_stall  (next_stall),
    .next_squash (next_squash)
  );

  always_ff @(posedge clk) begin
    if (d_reg_en) begin
      d_instr <= f_instr;
      d_pc    <= f_pc;
    end
  end

  // ==============================
  // field decode
  // ==============================

  // opcodes outside the five known ones behave as NOP
  always_comb begin
    case (d_instr[OP_LSB +: OP_W])
      ADD:     d_op = ADD;
      ADDI:    d_op = ADDI;
      MUL:     d_op = MUL;
      JMP:     d_op = JMP;
      default: d_op = NOP;
    endcase
  end

  assign d_rd = d_instr[RD_LSB +: RADDR_W];
  assign rs   = d_instr[RS_LSB +: RADDR_W];
  assign rt   = d_instr[RT_LSB +: RADDR_W];
  assign imm  = d_instr[IMM_LSB +: IMM_W];

  // ==============================
  // register file
  // ==============================

  // all registers read as zero after reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        rf[i] <= '0;
      end
    end else if (rf_wen) begin
      rf[rf_waddr] <= rf_wdata;
    end
  end

  // writeback bypasses the array so this cycle's write is seen at once
  assign d_a     = (rf_wen && rf_waddr == rs) ? rf_wdata : rf[rs];
  assign rt_data = (rf_wen && rf_waddr == rt) ? rf_wdata : rf[rt];

  // ADDI and JMP carry the sign-extended immediate in the second operand
  assign d_b = (d_op == ADDI || d_op == JMP) ?
               {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm} : rt_data;

  // hold here while execute still owes a register this instruction reads,
  // writeback is covered by the write-through path
  assign raw_stall = x_dest_val &&
                     (((d_op == ADD || d_op == ADDI || d_op == MUL) && x_dest == rs) ||
                      ((d_op == ADD || d_op == MUL) && x_dest == rt));

endmodule

// ==== verilog/exec_stage.sv ====
/*
 * execute stage: one-cycle adder, shift-add multiplier sequenced over
 * several cycles, and jump resolution that squashes the front end
 */

`timescale 1ns/1ps

module exec_stage
  import pipe_isa_pkg::*, pipe_cfg_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      d_val,
  input  opcode_e   d_op,
  input  reg_addr_t d_rd,
  input  word_t     d_a,
  input  word_t     d_b,
  input  pc_t       d_pc,
  input  logic      next_stall,
  input  logic      next_squash,
  output logic      prev_stall,
  output logic      prev_squash,
  output reg_addr_t x_dest,
  output logic      x_dest_val,
  output pc_t       redirect_pc,
  output logic      x_val,
  output reg_addr_t x_rd,
  output word_t     x_result,
  output logic      x_wen
);

  logic                 x_reg_en;
  logic                 x_curr_val;
  logic                 mul_stall;
  logic                 jmp_squash;
  opcode_e              x_op;
  word_t                x_a;
  word_t                x_b;
  pc_t                  x_pc;
  exec_state_e          state;
  logic [MUL_CNT_W-1:0] mul_cnt;
  word_t                mul_acc;
  word_t                step_sum;
  logic                 mul_go;
  logic                 mul_last;

  pipe_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .prev_val    (d_val),
    .prev_stall  (prev_stall),
    .prev_squash (prev_squash),
    .curr_reg_en (x_reg_en),
    .curr_val    (x_curr_val),
    .curr_stall  (mul_stall),
    .curr_squash (jmp_squash),
    .next_val    (x_val),
    .next_stall  (next_stall),
    .next_squash (next_squash)
  );

  always_ff @(posedge clk) begin
    if (x_reg_en) begin
      x_op <= d_op;
      x_rd <= d_rd;
      x_a  <= d_a;
      x_b  <= d_b;
      x_pc <= d_pc;
    end
  end

  // ==============================
  // multiplier
  // ==============================

  assign mul_go   = x_curr_val && x_op == MUL;
  assign mul_last = (mul_cnt == MUL_CNT_W'(MUL_CYCLES - 1));

  // one step adds the shifted multiplicand for each set bit in the
  // current slice of the multiplier, carries past bit 15 are dropped
  always_comb begin
    int unsigned bit_idx;
    step_sum = mul_acc;
    for (int i = 0; i < MUL_STEP_BITS; i++) begin
      bit_idx = mul_cnt * MUL_STEP_BITS + i;
      if (bit_idx < WORD_W && x_b[bit_idx]) begin
        step_sum = step_sum + (x_a << bit_idx);
      end
    end
  end

  // the last step is combinational, so a MUL stalls on all but its final cycle
  assign mul_stall = mul_go && !mul_last;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      mul_cnt <= '0;
      mul_acc <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (mul_stall) begin
            state   <= MUL_BUSY;
            mul_cnt <= mul_cnt + 1'b1;
            mul_acc <= step_sum;
          end
        end
        MUL_BUSY: begin
          if (!mul_last) begin
            mul_cnt <= mul_cnt + 1'b1;
            mul_acc <= step_sum;
          end else if (!next_stall) begin
            // product handed to writeback, clear for the next MUL
            state   <= IDLE;
            mul_cnt <= '0;
            mul_acc <= '0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ==============================
  // result and jump
  // ==============================

  always_comb begin
    case (x_op)
      ADD, ADDI: x_result = x_a + x_b;
      MUL:       x_result = step_sum;
      default:   x_result = '0;
    endcase
  end

  assign x_wen = (x_op == ADD || x_op == ADDI || x_op == MUL);

  // destination seen by the decode interlock
  assign x_dest     = x_rd;
  assign x_dest_val = x_curr_val && x_wen;

  // jump target is relative to the JMP itself and wraps in the PC width
  assign jmp_squash  = x_curr_val && x_op == JMP;
  assign redirect_pc = x_pc + pc_t'(x_b);

endmodule

// ==== verilog/wb_stage.sv ====
/*
 * writeback stage: registers the execute result and drives both the
 * register-file write and the external writeback port
 */

`timescale 1ns/1ps

module wb_stage
  import pipe_isa_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      x_val,
  input  reg_addr_t x_rd,
  input  word_t     x_result,
  input  logic      x_wen,
  output logic      prev_stall,
  output logic      prev_squash,
  output logic      rf_wen,
  output reg_addr_t rf_waddr,
  output word_t     rf_wdata,
  output logic      wb_val,
  output reg_addr_t wb_addr,
  output word_t     wb_data
);

  logic      w_reg_en;
  logic      w_curr_val;
  logic      w_wen;
  reg_addr_t w_rd;
  word_t     w_result;

  // last stage, so nothing behind it can stall or squash
  pipe_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .prev_val    (x_val),
    .prev_stall  (prev_stall),
    .prev_squash (prev_squash),
    .curr_reg_en (w_reg_en),
    .curr_val    (w_curr_val),
    .curr_stall  (1'b0),
    .curr_squash (1'b0),
    .next_val    (),
    .next_stall  (1'b0),
    .next_squash (1'b0)
  );

  always_ff @(posedge clk) begin
    if (w_reg_en) begin
      w_wen    <= x_wen;
      w_rd     <= x_rd;
      w_result <= x_result;
    end
  end

  // only a valid instruction with a destination commits
  assign rf_wen   = w_curr_val && w_wen;
  assign rf_waddr = w_rd;
  assign rf_wdata = w_result;

  // the outside sees exactly what goes into the register file
  assign wb_val  = rf_wen;
  assign wb_addr = w_rd;
  assign wb_data = w_result;

endmodule

// ==== verilog/tiny_pipe.sv ====
/*
 * tiny_pipe top level: four-stage in-order pipeline built from fetch,
 * decode, execute and writeback with stall and squash chained backward
 */

`timescale 1ns/1ps

module tiny_pipe
  import pipe_isa_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  instr_t    imem_data,
  output pc_t       imem_addr,
  output logic      wb_val,
  output reg_addr_t wb_addr,
  output word_t     wb_data
);

  // ==============================
  // stage to stage signals
  // ==============================

  // fetch to decode
  logic      f_val;
  instr_t    f_instr;
  pc_t       f_pc;

  // decode to execute, and the requests coming back
  logic      d_val;
  opcode_e   d_op;
  reg_addr_t d_rd;
  word_t     d_a;
  word_t     d_b;
  pc_t       d_pc;
  logic      d_stall;
  logic      d_squash;

  // execute to writeback, interlock info and jump target
  logic      x_val;
  reg_addr_t x_rd;
  word_t     x_result;
  logic      x_wen;
  reg_addr_t x_dest;
  logic      x_dest_val;
  pc_t       redirect_pc;
  logic      x_stall;
  logic      x_squash;

  // writeback back to execute and into the register file
  logic      w_stall;
  logic      w_squash;
  logic      rf_wen;
  reg_addr_t rf_waddr;
  word_t     rf_wdata;

  fetch_stage u_fetch (
    .clk         (clk),
    .rst_n       (rst_n),
    .next_stall  (d_stall),
    .next_squash (d_squash),
    .redirect_pc (redirect_pc),
    .imem_data   (imem_data),
    .imem_addr   (imem_addr),
    .f_val       (f_val),
    .f_instr     (f_instr),
    .f_pc        (f_pc)
  );

  decode_stage u_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .f_val       (f_val),
    .f_instr     (f_instr),
    .f_pc        (f_pc),
    .next_stall  (x_stall),
    .next_squash (x_squash),
    .x_dest      (x_dest),
    .x_dest_val  (x_dest_val),
    .rf_wen      (rf_wen),
    .rf_waddr    (rf_waddr),
    .rf_wdata    (rf_wdata),
    .prev_stall  (d_stall),
    .prev_squash (d_squash),
    .d_val       (d_val),
    .d_op        (d_op),
    .d_rd        (d_rd),
    .d_a         (d_a),
    .d_b         (d_b),
    .d_pc        (d_pc)
  );

  exec_stage u_exec (
    .clk         (clk),
    .rst_n       (rst_n),
    .d_val       (d_val),
    .d_op        (d_op),
    .d_rd        (d_rd),
    .d_a         (d_a),
    .d_b         (d_b),
    .d_pc        (d_pc),
    .next_stall  (w_stall),
    .next_squash (w_squash),
    .prev_stall  (x_stall),
    .prev_squash (x_squash),
    .x_dest      (x_dest),
    .x_dest_val  (x_dest_val),
    .redirect_pc (redirect_pc),
    .x_val       (x_val),
    .x_rd        (x_rd),
    .x_result    (x_result),
    .x_wen       (x_wen)
  );

  wb_stage u_wb (
    .clk         (clk),
    .rst_n       (rst_n),
    .x_val       (x_val),
    .x_rd        (x_rd),
    .x_result    (x_result),
    .x_wen       (x_wen),
    .prev_stall  (w_stall),
    .prev_squash (w_squash),
    .rf_wen      (rf_wen),
    .rf_waddr    (rf_waddr),
    .rf_wdata    (rf_wdata),
    .wb_val      (wb_val),
    .wb_addr     (wb_addr),
    .wb_data     (wb_data)
  );

endmodule

// ==== sim/clk_rst_gen.sv ====
/*
 * testbench clock and reset source: 8 ns clock, active-low reset held
 * for four cycles at start and again on each request
 */

`timescale 1ns/1ps

module clk_rst_gen (
  output logic clk,
  output logic rst_n,
  input  logic rst_req
);

  localparam int RESET_CYCLES = 4;

  int cnt;

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    cnt   = RESET_CYCLES - 1;
  end

  always #4 clk = ~clk;

  // a request restarts the count, release happens on a rising edge
  always @(posedge clk) begin
    if (rst_req) begin
      rst_n <= 1'b0;
      cnt   <= RESET_CYCLES - 1;
    end else if (cnt != 0) begin
      cnt <= cnt - 1;
    end else begin
      rst_n <= 1'b1;
    end
  end

endmodule

// ==== sim/tiny_pipe_props.sv ====
/*
 * concurrent checks on one pipe_ctrl instance: valid bit consistency
 * with stall, squash and reset
 */

`timescale 1ns/1ps

module tiny_pipe_props (
  input logic clk,
  input logic rst_n,
  input logic prev_val,
  input logic prev_stall,
  input logic curr_val,
  input logic next_val,
  input logic next_squash
);

  // a stage that holds up the stages before it keeps its instruction
  stall_keeps_val: assert property (
    @(posedge clk) disable iff (!rst_n) prev_stall |=> curr_val)
    else $error("pipe_ctrl dropped an instruction while stalling upstream");

  // an instruction that moves on with nothing behind it leaves the stage empty
  leave_clears_val: assert property (
    @(posedge clk) disable iff (!rst_n) next_val && !prev_val |=> !curr_val)
    else $error("pipe_ctrl kept an instruction that had already moved on");

  // a squashed instruction never leaves, and the slot is empty afterwards
  squash_empties_stage: assert property (
    @(posedge clk) disable iff (!rst_n) next_squash |-> !next_val ##1 !curr_val)
    else $error("pipe_ctrl let a squashed instruction through or kept it");

  // first cycle out of reset, every stage is still empty
  reset_clears_val: assert property (
    @(posedge clk) $rose(rst_n) |-> !curr_val)
    else $error("pipe_ctrl valid bit set right after reset release");

endmodule

// ==== sim/tiny_pipe_tb.sv ====
/*
 * tiny_pipe testbench: runs a table of small programs from a modelled
 * instruction memory and checks the writeback stream against a reference
 * interpreter of the instruction set
 */

`timescale 1ns/1ps

module tiny_pipe_tb
  import pipe_isa_pkg::*, pipe_cfg_pkg::*;
();

  localparam int          NUM_PROGS = 5;
  localparam int          MAX_LEN   = 16;
  localparam logic [31:0] SEED      = 32'h7074_bcc5;

  logic      clk;
  logic      rst_n;
  logic      rst_req;
  instr_t    imem_data;
  pc_t       imem_addr;
  logic      wb_val;
  reg_addr_t wb_addr;
  word_t     wb_data;

  // program table, one row per named program
  string  prog_name [NUM_PROGS];
  instr_t prog_word [NUM_PROGS][MAX_LEN];
  int     prog_len  [NUM_PROGS];
  int     cur;

  // writebacks the reference interpreter expects, in retire order
  reg_addr_t exp_addr [$];
  word_t     exp_data [$];

  clk_rst_gen u_clk_rst (
    .clk     (clk),
    .rst_n   (rst_n),
    .rst_req (rst_req)
  );

  tiny_pipe u_tiny_pipe (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_data (imem_data),
    .imem_addr (imem_addr),
    .wb_val    (wb_val),
    .wb_addr   (wb_addr),
    .wb_data   (wb_data)
  );

  bind pipe_ctrl tiny_pipe_props u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .prev_val    (prev_val),
    .prev_stall  (prev_stall),
    .curr_val    (curr_val),
    .next_val    (next_val),
    .next_squash (next_squash)
  );

  // ==============================
  // helpers
  // ==============================

  task automatic stop_with_failure(string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_addr(string what, reg_addr_t exp, reg_addr_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("[FAIL] %s %s: expected %0d, got %0d",
                                  prog_name[cur], what, exp, act));
    end
  endtask

  task automatic check_data(string what, word_t exp, word_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("[FAIL] %s %s: expected %h, got %h",
                                  prog_name[cur], what, exp, act));
    end
  endtask

  task automatic check_pc(string what, pc_t exp, pc_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("[FAIL] %s %s: expected %h, got %h",
                                  prog_name[cur], what, exp, act));
    end
  endtask

  task automatic check_flag(string what, logic exp, logic act);
    if (act !== exp) begin
      stop_with_failure($sformatf("[FAIL] %s %s: expected %b, got %b",
                                  prog_name[cur], what, exp, act));
    end
  endtask

  // instruction word from its fields, low is rt or the 7-bit immediate
  function automatic instr_t encode(opcode_e op, int rd, int rs, int low);
    instr_t w;
    w = {op, rd[2:0], rs[2:0], low[6:0]};
    return w;
  endfunction

  function automatic int rand_imm();
    return int'($urandom_range(127, 0));
  endfunction

  // memory past the end of a program reads as NOP
  function automatic instr_t imem_read(pc_t addr);
    if (int'(addr) < prog_len[cur]) begin
      return prog_word[cur][addr];
    end
    return encode(NOP, 0, 0, 0);
  endfunction

  task automatic add_instr(int p, instr_t w);
    prog_word[p][prog_len[p]] = w;
    prog_len[p]++;
  endtask

  // ==============================
  // program table
  // ==============================

  task automatic build_programs();
    for (int p = 0; p < NUM_PROGS; p++) begin
      prog_len[p] = 0;
      for (int i = 0; i < MAX_LEN; i++) begin
        prog_word[p][i] = '0;
      end
    end
    // no source depends on the instruction just ahead of it
    prog_name[0] = "independent_alu";
    add_instr(0, encode(ADDI, 1, 0, rand_imm()));
    add_instr(0, encode(ADDI, 2, 0, rand_imm()));
    add_instr(0, encode(ADDI, 3, 0, rand_imm()));
    add_instr(0, encode(ADDI, 4, 0, rand_imm()));
    add_instr(0, encode(ADD, 5, 1, 2));
    add_instr(0, encode(ADD, 6, 3, 1));
    add_instr(0, encode(ADDI, 7, 2, rand_imm()));
    // every instruction reads the one right before it
    prog_name[1] = "raw_chain";
    add_instr(1, encode(ADDI, 1, 0, rand_imm()));
    add_instr(1, encode(ADDI, 1, 1, rand_imm()));
    add_instr(1, encode(ADD, 2, 1, 1));
    add_instr(1, encode(ADD, 3, 2, 1));
    add_instr(1, encode(ADDI, 3, 3, rand_imm()));
    add_instr(1, encode(ADD, 4, 3, 2));
    add_instr(1, encode(ADD, 4, 4, 4));
    // multiplies with dependents queued behind them
    prog_name[2] = "mul_chain";
    add_instr(2, encode(ADDI, 1, 0, rand_imm()));
    add_instr(2, encode(ADDI, 2, 0, rand_imm()));
    add_instr(2, encode(MUL, 3, 1, 2));
    add_instr(2, encode(ADDI, 4, 0, rand_imm()));
    add_instr(2, encode(MUL, 5, 3, 3));
    add_instr(2, encode(ADD, 6, 5, 3));
    add_instr(2, encode(MUL, 7, 6, 1));
    add_instr(2, encode(ADDI, 7, 7, 1));
    // jump over two instructions that must never retire
    prog_name[3] = "jmp_forward";
    add_instr(3, encode(ADDI, 1, 0, rand_imm()));
    add_instr(3, encode(JMP, 0, 0, 3));
    add_instr(3, encode(ADDI, 2, 0, rand_imm()));
    add_instr(3, encode(ADDI, 3, 0, rand_imm()));
    add_instr(3, encode(ADD, 4, 1, 1));
    add_instr(3, encode(MUL, 5, 4, 1));
    add_instr(3, encode(ADDI, 6, 5, rand_imm()));
    // path is 0, 1, 5, 6, 2, 3, 4, 7
    prog_name[4] = "jmp_backward";
    add_instr(4, encode(ADDI, 1, 0, rand_imm()));
    add_instr(4, encode(JMP, 0, 0, 4));
    add_instr(4, encode(ADDI, 2, 0, rand_imm()));
    add_instr(4, encode(ADD, 3, 2, 1));
    add_instr(4, encode(JMP, 0, 0, 3));
    add_instr(4, encode(ADDI, 4, 1, 1));
    add_instr(4, encode(JMP, 0, 0, -4));
    add_instr(4, encode(MUL, 5, 3, 4));
  endtask

  // ==============================
  // reference interpreter
  // ==============================

  // architectural model, one instruction at a time, registers start at zero
  task automatic run_reference(int p);
    word_t  regs [NUM_REGS];
    pc_t    pc;
    pc_t    next_pc;
    instr_t w;
    word_t  a;
    word_t  b;
    word_t  imm;
    int     steps;
    exp_addr.delete();
    exp_data.delete();
    for (int i = 0; i < NUM_REGS; i++) begin
      regs[i] = '0;
    end
    pc    = pc_t'(RESET_PC);
    steps = 0;
    while (int'(pc) < prog_len[p]) begin
      if (steps > 4 * MAX_LEN) begin
        stop_with_failure($sformatf("reference run of %s never reached its end",
                                    prog_name[p]));
      end
      w       = prog_word[p][pc];
      a       = regs[w[9:7]];
      b       = regs[w[2:0]];
      imm     = {{9{w[6]}}, w[6:0]};
      next_pc = pc + 8'd1;
      case (w[15:13])
        ADD: begin
          regs[w[12:10]] = a + b;
          exp_addr.push_back(w[12:10]);
          exp_data.push_back(a + b);
        end
        ADDI: begin
          regs[w[12:10]] = a + imm;
          exp_addr.push_back(w[12:10]);
          exp_data.push_back(a + imm);
        end
        MUL: begin
          // 16-bit operands into a 16-bit result keep the low half only
          regs[w[12:10]] = a * b;
          exp_addr.push_back(w[12:10]);
          exp_data.push_back(a * b);
        end
        JMP: next_pc = pc + imm[7:0];
        default: ;
      endcase
      pc = next_pc;
      steps++;
    end
  endtask

  // ==============================
  // cycle driver and program run
  // ==============================

  // inputs change 1 ns after the rising edge, outputs are read at the falling edge
  task automatic step_cycle(logic req);
    @(posedge clk);
    #1;
    rst_req   = req;
    imem_data = imem_read(imem_addr);
    @(negedge clk);
  endtask

  task automatic run_program(int p);
    int limit;
    int cycles;
    int seen;
    bit done;
    cur = p;
    run_reference(p);
    limit = prog_len[p] * (MUL_CYCLES + 4) + 20;
    step_cycle(1'b1);
    step_cycle(1'b0);
    cycles = 0;
    while (!rst_n) begin
      if (cycles > 10) begin
        stop_with_failure("reset was not released by the clock generator");
      end
      step_cycle(1'b0);
      cycles++;
    end
    check_flag("wb_val after reset", 1'b0, wb_val);
    check_pc("imem_addr after reset", pc_t'(RESET_PC), imem_addr);
    // run until fetch is four words past the end, so the last real
    // instruction has already left writeback
    cycles = 0;
    seen   = 0;
    done   = 1'b0;
    while (!done) begin
      step_cycle(1'b0);
      cycles++;
      if (wb_val) begin
        if (seen >= exp_addr.size()) begin
          stop_with_failure($sformatf("%s retired an extra writeback to r%0d",
                                      prog_name[p], wb_addr));
        end
        check_addr($sformatf("writeback %0d address", seen), exp_addr[seen], wb_addr);
        check_data($sformatf("writeback %0d data", seen), exp_data[seen], wb_data);
        seen++;
      end
      if (int'(imem_addr) >= prog_len[p] + 4) begin
        done = 1'b1;
      end else if (cycles >= limit) begin
        stop_with_failure($sformatf("%s did not finish within %0d cycles",
                                    prog_name[p], limit));
      end
    end
    if (seen != exp_addr.size()) begin
      stop_with_failure($sformatf("%s retired %0d writebacks where %0d were expected",
                                  prog_name[p], seen, exp_addr.size()));
    end
    $display("%s: %0d writebacks matched", prog_name[p], seen);
  endtask

  initial begin
    rst_req   = 1'b0;
    imem_data = '0;
    cur       = 0;
    void'($urandom(SEED));
    build_programs();
    for (int p = 0; p < NUM_PROGS; p++) begin
      run_program(p);
    end
    $display("Test passed");
    $finish;
  end

endmodule

// ==== list.f ====
verilog/pipe_isa_pkg.sv
verilog/pipe_cfg_pkg.sv
verilog/pipe_ctrl.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/exec_stage.sv
verilog/wb_stage.sv
verilog/tiny_pipe.sv
sim/clk_rst_gen.sv
sim/tiny_pipe_props.sv
sim/tiny_pipe_tb.sv

// ==== Makefile ====
TOP := tiny_pipe_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
